//--- common/fscpu_cfg.svh
`ifndef FSCPU_CFG_SVH
`define FSCPU_CFG_SVH

// motor datapath
`define FSCPU_SPEED_W      32
`define FSCPU_STEP_W       32

// discharge pwm
`define FSCPU_PWM_CNT_W    16
`define FSCPU_PWM_NUM_W    32

// request port, 32-bit parameter words
`define FSCPU_PARAM_WORDS  5

`define FSCPU_DEV_W        32

// bitmap positions, equal to the record command codes
`define FSCPU_DBIT_LR         4
`define FSCPU_DBIT_RR         5
`define FSCPU_DBIT_DISCHARGE  8

`define FSCPU_CMD_CFG   29
`define FSCPU_CMD_EXE   30
`define FSCPU_CMD_STOP  31

`endif

//--- common/fscpu_pkg.sv
`include "fscpu_cfg.svh"

package fscpu_pkg;

	typedef enum logic [31:0] {
		CMD_MOTOR_LR  = `FSCPU_DBIT_LR,
		CMD_MOTOR_RR  = `FSCPU_DBIT_RR,
		CMD_DISCHARGE = `FSCPU_DBIT_DISCHARGE,
		CMD_CFG       = `FSCPU_CMD_CFG,
		CMD_EXE       = `FSCPU_CMD_EXE,
		CMD_STOP      = `FSCPU_CMD_STOP,
		CMD_OTHER     = 32'hffff_ffff	// anything not handled here
	} req_cmd_e;

	typedef struct packed {
		logic                                valid;
		req_cmd_e                            cmd;
		logic [`FSCPU_PARAM_WORDS-1:0][31:0] par;	// par[0] is the low word
	} req_s;

	typedef struct packed {
		logic                            abs;
		logic [`FSCPU_SPEED_W-1:0]       speed;
		logic signed [`FSCPU_STEP_W-1:0] step;
	} motor_req_s;

	typedef struct packed {
		logic                            start;
		logic                            stop;
		logic                            abs;
		logic [`FSCPU_SPEED_W-1:0]       speed;
		logic signed [`FSCPU_STEP_W-1:0] step;
	} motor_cmd_s;

	typedef struct packed {
		logic [`FSCPU_PWM_CNT_W-1:0] denominator;
		logic [`FSCPU_PWM_CNT_W-1:0] numerator0;
		logic [`FSCPU_PWM_CNT_W-1:0] numerator1;
		logic [`FSCPU_PWM_NUM_W-1:0] number0;
		logic [`FSCPU_PWM_NUM_W-1:0] number1;
	} discharge_req_s;

	typedef enum logic [2:0] {M_IDLE, M_START, M_WAIT_BUSY, M_WAIT_IDLE, M_DONE} motor_state_e;

	typedef enum logic [1:0] {D_IDLE, D_PHASE0, D_PHASE1, D_DONE} dis_phase_e;

endpackage

//--- compile.f
+incdir+common
common/fscpu_pkg.sv
verilog/req_decode.sv
verilog/dev_dispatch.sv
motor/rotate_motor_ctl.sv
discharge/discharge_ctl.sv
verilog/fscpu_top.sv
testbench/motor_model.sv
testbench/tb_fscpu.sv

//--- discharge/discharge_ctl.sv
`timescale 1ns/10ps
`include "fscpu_cfg.svh"

module discharge_ctl (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      i_enable,
	input  fscpu_pkg::discharge_req_s i_req,
	output logic                      o_done,
	output logic                      o_discharge_resetn,
	output logic                      o_discharge_drive
);
	import fscpu_pkg::*;

	dis_phase_e                  phase;
	logic [`FSCPU_PWM_CNT_W-1:0] pwm_cnt;
	logic [`FSCPU_PWM_NUM_W-1:0] period_cnt;
	discharge_req_s              req_q;
	logic                        period_end;
	logic [`FSCPU_PWM_NUM_W-1:0] period_num;
	logic [`FSCPU_PWM_CNT_W-1:0] numerator;

	// settings of the running phase
	always_comb begin
		if (phase == D_PHASE1) begin
			period_num = req_q.number1;
			numerator  = req_q.numerator1;
		end else begin
			period_num = req_q.number0;
			numerator  = req_q.numerator0;
		end
	end

	assign period_end = (pwm_cnt == req_q.denominator - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn || !i_enable) begin
			phase      <= D_IDLE;
			pwm_cnt    <= '0;
			period_cnt <= '0;
		end else begin
			case (phase)
				D_IDLE: begin
					// empty phases are skipped
					if (i_req.number0 != '0)
						phase <= D_PHASE0;
					else if (i_req.number1 != '0)
						phase <= D_PHASE1;
					else
						phase <= D_DONE;
				end
				D_PHASE0, D_PHASE1: begin
					if (period_end) begin
						pwm_cnt <= '0;
						if (period_cnt == period_num - 1'b1) begin
							period_cnt <= '0;
							if (phase == D_PHASE0 && req_q.number1 != '0)
								phase <= D_PHASE1;
							else
								phase <= D_DONE;
						end else begin
							period_cnt <= period_cnt + 1'b1;
						end
					end else begin
						pwm_cnt <= pwm_cnt + 1'b1;
					end
				end
				default:
					phase <= D_DONE;	// parks until disabled
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == D_IDLE)
			req_q <= i_req;
	end

	assign o_discharge_resetn = (phase == D_PHASE0) || (phase == D_PHASE1);
	assign o_discharge_drive  = o_discharge_resetn && (pwm_cnt < numerator);	// head of period
	assign o_done             = (phase == D_DONE);

	// counter stays inside the period
	a_pwm_in_period: assert property (@(posedge clk) disable iff (!resetn)
		(phase inside {D_PHASE0, D_PHASE1}) |-> (pwm_cnt < req_q.denominator));

endmodule

//--- motor/rotate_motor_ctl.sv
`timescale 1ns/10ps

module rotate_motor_ctl (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  i_enable,
	input  fscpu_pkg::motor_req_s i_req,
	input  logic                  i_m_state,
	output fscpu_pkg::motor_cmd_s o_cmd,
	output logic                  o_done
);
	import fscpu_pkg::*;

	motor_state_e state;
	logic         start_q;
	logic         stop_q;
	logic         enable_q;
	motor_req_s   req_q;

	// a disabled executor is held in reset
	always_ff @(posedge clk) begin
		if (!resetn || !i_enable) begin
			state   <= M_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				M_IDLE: begin
					state   <= M_START;
					start_q <= 1'b1;
				end
				M_START:
					state <= M_WAIT_BUSY;
				M_WAIT_BUSY:
					if (i_m_state)
						state <= M_WAIT_IDLE;
				M_WAIT_IDLE:
					if (!i_m_state)
						state <= M_DONE;
				M_DONE:
					state <= M_DONE;
				default:
					state <= M_IDLE;
			endcase
		end
	end

	// payload follows the record until the start goes out
	always_ff @(posedge clk) begin
		if (state == M_IDLE)
			req_q <= i_req;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			enable_q <= 1'b0;
			stop_q   <= 1'b0;
		end else begin
			enable_q <= i_enable;
			stop_q   <= enable_q && !i_enable && i_m_state;	// cancelled mid move
		end
	end

	assign o_cmd = '{
		start: start_q,
		stop:  stop_q,
		abs:   req_q.abs,
		speed: req_q.speed,
		step:  req_q.step
	};

	assign o_done = (state == M_DONE);

	a_start_stop: assert property (@(posedge clk) disable iff (!resetn)
		!(o_cmd.start && o_cmd.stop));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fscpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fscpu \
	-f compile.f -o sim_fscpu > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_fscpu > sim.log 2>&1
grep -q "^Simulation completed successfully$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

//--- testbench/motor_model.sv
`timescale 1ns/10ps

module motor_model (
	input  logic                  clk,
	input  logic                  resetn,
	input  fscpu_pkg::motor_cmd_s i_cmd,
	output logic                  o_busy
);
	import fscpu_pkg::*;

	logic [31:0] mag;
	logic [4:0]  run_len;
	logic [4:0]  hold_cnt;
	logic        pending;

	// step magnitude picks the move length
	assign mag = i_cmd.step[31] ? -i_cmd.step : i_cmd.step;

	always @(posedge clk) begin
		if (!resetn) begin
			o_busy   <= 1'b0;
			pending  <= 1'b0;
			hold_cnt <= '0;
			run_len  <= '0;
		end else if (i_cmd.stop) begin
			o_busy  <= 1'b0;	// abort the move
			pending <= 1'b0;
		end else if (i_cmd.start) begin
			pending <= 1'b1;
			run_len <= {1'b0, mag[3:0]} + 5'd1;
		end else if (pending) begin
			pending  <= 1'b0;
			o_busy   <= 1'b1;	// two cycles after start
			hold_cnt <= run_len;
		end else if (o_busy) begin
			if (hold_cnt == 5'd1)
				o_busy <= 1'b0;
			hold_cnt <= hold_cnt - 5'd1;
		end
	end

endmodule

//--- testbench/tb_fscpu.sv
`timescale 1ns/10ps

module tb_fscpu;
	import fscpu_pkg::*;

	typedef enum int {EXP_REC, EXP_EMPTY, EXP_LR, EXP_BOTH, EXP_DIS, EXP_BUSY, EXP_STOP} exp_e;

	typedef struct packed {
		logic [31:0] cmd;
		logic [31:0] p0;
		logic [31:0] p1;
		logic [31:0] p2;
		exp_e        chk;
		int          test;
		int          cycles;	// expected length of the row
	} row_s;

	typedef struct packed {
		int lr_start;
		int rr_start;
		int lr_stop;
		int drive;
		int dres;
		int lr_busy;
		int rr_busy;
	} mon_s;

	logic           clk = 1'b0;
	logic           resetn;
	logic           req_en;
	logic [31:0]    req_cmd;
	logic [159:0]   req_param;
	logic           req_done;
	logic           lr_state;
	logic           rr_state;
	motor_cmd_s     lr_cmd;
	motor_cmd_s     rr_cmd;
	logic           dis_resetn;
	logic           dis_drive;
	row_s           rows[$];
	logic           table_ready = 1'b0;
	mon_s           mon;
	mon_s           base;
	motor_cmd_s     lr_pay;
	motor_cmd_s     rr_pay;
	motor_req_s     exp_lr;
	motor_req_s     exp_rr;
	discharge_req_s exp_dis;
	int unsigned    seed_val;

	always #2 clk = ~clk;

	fscpu_top uut (
		.clk                (clk),
		.resetn             (resetn),
		.i_req_en           (req_en),
		.i_req_cmd          (req_cmd),
		.i_req_param        (req_param),
		.o_req_done         (req_done),
		.i_lr_state         (lr_state),
		.o_lr_cmd           (lr_cmd),
		.i_rr_state         (rr_state),
		.o_rr_cmd           (rr_cmd),
		.o_discharge_resetn (dis_resetn),
		.o_discharge_drive  (dis_drive)
	);

	motor_model u_lr_model (.clk(clk), .resetn(resetn), .i_cmd(lr_cmd), .o_busy(lr_state));
	motor_model u_rr_model (.clk(clk), .resetn(resetn), .i_cmd(rr_cmd), .o_busy(rr_state));

	// activity counters, sampled on the rising edge
	always @(posedge clk) begin
		if (!resetn) begin
			mon <= '0;
		end else begin
			if (lr_cmd.start) begin
				mon.lr_start <= mon.lr_start + 1;
				lr_pay       <= lr_cmd;
			end
			if (rr_cmd.start) begin
				mon.rr_start <= mon.rr_start + 1;
				rr_pay       <= rr_cmd;
			end
			if (lr_cmd.stop)
				mon.lr_stop <= mon.lr_stop + 1;
			if (dis_drive)
				mon.drive <= mon.drive + 1;
			if (dis_resetn)
				mon.dres <= mon.dres + 1;
			if (lr_state)
				mon.lr_busy <= mon.lr_busy + 1;
			if (rr_state)
				mon.rr_busy <= mon.rr_busy + 1;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	function automatic string test_label(input int t);
		case (t)
			1: return "reset_empty_exe";
			2: return "lr_single";
			3: return "lr_rr_pair";
			4: return "discharge_pwm";
			5: return "lr_stop";
			default: return "lr_rr_random";
		endcase
	endfunction

	// model busy length, |step| mod 16 plus one
	function automatic int busy_len(input logic [31:0] step);
		logic [31:0] mag;
		mag = step[31] ? -step : step;
		return int'(mag % 16) + 1;
	endfunction

	task automatic step_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic add_row(input logic [31:0] cmd, input logic [31:0] p0, input logic [31:0] p1,
			input logic [31:0] p2, input exp_e chk, input int test, input int cycles);
		rows.push_back(row_s'{cmd, p0, p1, p2, chk, test, cycles});
	endtask

	task automatic build_table();
		add_row(CMD_EXE, 0, 0, 0, EXP_EMPTY, 1, 12);
		add_row(CMD_MOTOR_LR, 32'h2, 32'd1000, -32'sd7, EXP_REC, 2, 2);
		add_row(CMD_EXE, 0, 0, 0, EXP_LR, 2, 30);
		add_row(CMD_MOTOR_LR, 32'h0, 32'd250, 32'd12, EXP_REC, 3, 2);
		add_row(CMD_MOTOR_RR, 32'h2, 32'd777, -32'sd3, EXP_REC, 3, 2);
		add_row(CMD_EXE, 0, 0, 0, EXP_BOTH, 3, 30);
		add_row(CMD_CFG, 0, 0, 32'd5, EXP_REC, 4, 2);
		add_row(CMD_DISCHARGE, {16'd3, 16'd2}, 32'd3, 32'd2, EXP_REC, 4, 2);
		add_row(CMD_EXE, 0, 0, 0, EXP_DIS, 4, 40);
		add_row(CMD_MOTOR_LR, 32'h0, 32'd500, 32'd15, EXP_REC, 5, 2);
		add_row(CMD_EXE, 0, 0, 0, EXP_BUSY, 5, 10);
		add_row(CMD_STOP, 0, 0, 0, EXP_STOP, 5, 24);
		add_row(CMD_MOTOR_LR, $urandom(), $urandom(), $urandom(), EXP_REC, 6, 2);
		add_row(CMD_MOTOR_RR, $urandom(), $urandom(), $urandom(), EXP_REC, 6, 2);
		add_row(CMD_EXE, 0, 0, 0, EXP_BOTH, 6, 30);
		add_row(CMD_STOP, 0, 0, 0, EXP_REC, 6, 2);	// drops the done level
	endtask

	task automatic apply_row(input row_s r);
		string name;
		name = test_label(r.test);
		base = mon;
		@(posedge clk);
		#1;
		req_en    = 1'b1;
		req_cmd   = r.cmd;
		req_param = {64'h0, r.p2, r.p1, r.p0};
		step_cycles(1);
		req_en = 1'b0;
		step_cycles(1);
		check({name, " done cleared"}, 0, req_done);
		if (r.cmd == CMD_MOTOR_LR)
			exp_lr = '{abs: r.p0[1], speed: r.p1, step: r.p2};
		if (r.cmd == CMD_MOTOR_RR)
			exp_rr = '{abs: r.p0[1], speed: r.p1, step: r.p2};
		if (r.cmd == CMD_CFG)
			exp_dis.denominator = r.p2[15:0];
		if (r.cmd == CMD_DISCHARGE) begin
			exp_dis.numerator0 = r.p0[15:0];
			exp_dis.numerator1 = r.p0[31:16];
			exp_dis.number0    = r.p1;
			exp_dis.number1    = r.p2;
		end
		case (r.chk)
			EXP_EMPTY: begin
				step_cycles(10);
				check({name, " done"}, 0, req_done);
				check({name, " lr starts"}, 0, mon.lr_start - base.lr_start);
				check({name, " rr starts"}, 0, mon.rr_start - base.rr_start);
			end
			EXP_LR, EXP_BOTH: begin
				while (!req_done)
					step_cycles(1);
				check({name, " lr starts"}, 1, mon.lr_start - base.lr_start);
				check({name, " lr abs"}, exp_lr.abs, lr_pay.abs);
				check({name, " lr speed"}, exp_lr.speed, lr_pay.speed);
				check({name, " lr step"}, exp_lr.step, lr_pay.step);
				check({name, " lr busy"}, busy_len(exp_lr.step), mon.lr_busy - base.lr_busy);
				check({name, " lr idle"}, 0, lr_state);
				if (r.chk == EXP_LR) begin
					check({name, " rr starts"}, 0, mon.rr_start - base.rr_start);
				end else begin
					check({name, " rr starts"}, 1, mon.rr_start - base.rr_start);
					check({name, " rr abs"}, exp_rr.abs, rr_pay.abs);
					check({name, " rr speed"}, exp_rr.speed, rr_pay.speed);
					check({name, " rr step"}, exp_rr.step, rr_pay.step);
					check({name, " rr busy"}, busy_len(exp_rr.step),
						mon.rr_busy - base.rr_busy);
					check({name, " rr idle"}, 0, rr_state);
				end
			end
			EXP_DIS: begin
				while (!req_done)
					step_cycles(1);
				check({name, " drive cycles"},
					64'(exp_dis.number0) * exp_dis.numerator0 +
					64'(exp_dis.number1) * exp_dis.numerator1, mon.drive - base.drive);
				check({name, " resetn cycles"},
					(64'(exp_dis.number0) + exp_dis.number1) * exp_dis.denominator,
					mon.dres - base.dres);
				check({name, " lr starts"}, 0, mon.lr_start - base.lr_start);
			end
			EXP_BUSY: begin
				while (!lr_state)
					step_cycles(1);
			end
			EXP_STOP: begin
				step_cycles(20);
				check({name, " stop pulses"}, 1, mon.lr_stop - base.lr_stop);
				check({name, " done"}, 0, req_done);
				check({name, " lr idle"}, 0, lr_state);
			end
			default: ;
		endcase
	endtask

	initial begin
		seed_val  = $urandom(32'h17d2);	// seeds the generator
		resetn    = 1'b0;
		req_en    = 1'b0;
		req_cmd   = '0;
		req_param = '0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		check("reset_empty_exe req_done", 0, req_done);
		check("reset_empty_exe lr start", 0, lr_cmd.start);
		check("reset_empty_exe lr stop", 0, lr_cmd.stop);
		check("reset_empty_exe rr start", 0, rr_cmd.start);
		check("reset_empty_exe rr stop", 0, rr_cmd.stop);
		check("reset_empty_exe discharge resetn", 0, dis_resetn);
		check("reset_empty_exe discharge drive", 0, dis_drive);
		foreach (rows[i])
			apply_row(rows[i]);
		$display("Simulation completed successfully");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		longint budget;
		budget = 0;
		wait (table_ready);
		foreach (rows[i])
			budget += rows[i].cycles + 20;
		#(budget * 4);
		abort_run("timeout: the request table did not finish within its cycle budget");
	end

endmodule

//--- verilog/dev_dispatch.sv
`timescale 1ns/10ps
`include "fscpu_cfg.svh"

module dev_dispatch (
	input  logic                      clk,
	input  logic                      resetn,
	input  fscpu_pkg::req_s           i_req,
	input  logic [`FSCPU_DEV_W-1:0]   i_done,
	output logic [`FSCPU_DEV_W-1:0]   o_enable,
	output fscpu_pkg::motor_req_s     o_lr_req,
	output fscpu_pkg::motor_req_s     o_rr_req,
	output fscpu_pkg::discharge_req_s o_dis_req,
	output logic                      o_req_done
);
	import fscpu_pkg::*;

	logic [`FSCPU_DEV_W-1:0] stage_bmp;
	logic [`FSCPU_DEV_W-1:0] oper_bmp;
	logic [`FSCPU_DEV_W-1:0] rec_bit;
	logic                    all_done;
	logic                    done_q;
	logic [31:0]             par0;
	logic [31:0]             par1;
	logic [31:0]             par2;
	motor_req_s              motor_rec [`FSCPU_DBIT_LR:`FSCPU_DBIT_RR];
	discharge_req_s          dis_rec;

	assign par0 = i_req.par[0];
	assign par1 = i_req.par[1];
	assign par2 = i_req.par[2];

	always_ff @(posedge clk) begin
		for (int d = `FSCPU_DBIT_LR; d <= `FSCPU_DBIT_RR; d++) begin
			if (i_req.valid && i_req.cmd == req_cmd_e'(d)) begin
				motor_rec[d].abs   <= par0[1];
				motor_rec[d].speed <= par1[`FSCPU_SPEED_W-1:0];
				motor_rec[d].step  <= par2[`FSCPU_STEP_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_req.valid && i_req.cmd == CMD_CFG)
			dis_rec.denominator <= par2[`FSCPU_PWM_CNT_W-1:0];
		if (i_req.valid && i_req.cmd == CMD_DISCHARGE) begin
			dis_rec.numerator0 <= par0[`FSCPU_PWM_CNT_W-1:0];
			dis_rec.numerator1 <= par0[16 +: `FSCPU_PWM_CNT_W];
			dis_rec.number0    <= par1[`FSCPU_PWM_NUM_W-1:0];
			dis_rec.number1    <= par2[`FSCPU_PWM_NUM_W-1:0];
		end
	end

	always_comb begin
		rec_bit = '0;
		if (i_req.valid) begin
			case (i_req.cmd)
				CMD_MOTOR_LR:  rec_bit[`FSCPU_DBIT_LR] = 1'b1;
				CMD_MOTOR_RR:  rec_bit[`FSCPU_DBIT_RR] = 1'b1;
				CMD_DISCHARGE: rec_bit[`FSCPU_DBIT_DISCHARGE] = 1'b1;
				default:       rec_bit = '0;
			endcase
		end
	end

	assign all_done = ((i_done & oper_bmp) == oper_bmp) && (oper_bmp != '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end else if (i_req.valid && i_req.cmd == CMD_STOP) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end else if (i_req.valid && i_req.cmd == CMD_EXE) begin
			oper_bmp <= stage_bmp;
		end else if (all_done) begin
			// both clear together, every executor sees a reset cycle
			stage_bmp <= rec_bit;
			oper_bmp  <= '0;
		end else begin
			stage_bmp <= stage_bmp | rec_bit;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			done_q <= 1'b0;
		else if (i_req.valid)
			done_q <= 1'b0;	// any request drops it
		else if (all_done)
			done_q <= 1'b1;
	end

	assign o_enable   = oper_bmp;
	assign o_lr_req   = motor_rec[`FSCPU_DBIT_LR];
	assign o_rr_req   = motor_rec[`FSCPU_DBIT_RR];
	assign o_dis_req  = dis_rec;
	assign o_req_done = done_q;

	// nothing runs unless it was staged first
	a_oper_in_stage: assert property (@(posedge clk) disable iff (!resetn)
		(oper_bmp == '0) || ((oper_bmp & ~stage_bmp) == '0));

endmodule

//--- verilog/fscpu_top.sv
`timescale 1ns/10ps
`include "fscpu_cfg.svh"

module fscpu_top (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             i_req_en,
	input  logic [31:0]                      i_req_cmd,
	input  logic [`FSCPU_PARAM_WORDS*32-1:0] i_req_param,
	output logic                             o_req_done,
	input  logic                             i_lr_state,
	output fscpu_pkg::motor_cmd_s            o_lr_cmd,
	input  logic                             i_rr_state,
	output fscpu_pkg::motor_cmd_s            o_rr_cmd,
	output logic                             o_discharge_resetn,
	output logic                             o_discharge_drive
);
	import fscpu_pkg::*;

	req_s                    dec_req;
	logic [`FSCPU_DEV_W-1:0] enable_bmp;
	wire  [`FSCPU_DEV_W-1:0] done_bmp;
	motor_req_s              lr_req;
	motor_req_s              rr_req;
	discharge_req_s          dis_req;

	// unused device slots never report done
	assign done_bmp[`FSCPU_DBIT_LR-1:0] = '0;
	assign done_bmp[`FSCPU_DBIT_DISCHARGE-1:`FSCPU_DBIT_RR+1] = '0;
	assign done_bmp[`FSCPU_DEV_W-1:`FSCPU_DBIT_DISCHARGE+1] = '0;

	req_decode u_decode (
		.clk         (clk),
		.resetn      (resetn),
		.i_req_en    (i_req_en),
		.i_req_cmd   (i_req_cmd),
		.i_req_param (i_req_param),
		.o_req       (dec_req)
	);

	dev_dispatch u_dispatch (
		.clk        (clk),
		.resetn     (resetn),
		.i_req      (dec_req),
		.i_done     (done_bmp),
		.o_enable   (enable_bmp),
		.o_lr_req   (lr_req),
		.o_rr_req   (rr_req),
		.o_dis_req  (dis_req),
		.o_req_done (o_req_done)
	);

	rotate_motor_ctl u_lr_motor (
		.clk       (clk),
		.resetn    (resetn),
		.i_enable  (enable_bmp[`FSCPU_DBIT_LR]),
		.i_req     (lr_req),
		.i_m_state (i_lr_state),
		.o_cmd     (o_lr_cmd),
		.o_done    (done_bmp[`FSCPU_DBIT_LR])
	);

	rotate_motor_ctl u_rr_motor (
		.clk       (clk),
		.resetn    (resetn),
		.i_enable  (enable_bmp[`FSCPU_DBIT_RR]),
		.i_req     (rr_req),
		.i_m_state (i_rr_state),
		.o_cmd     (o_rr_cmd),
		.o_done    (done_bmp[`FSCPU_DBIT_RR])
	);

	discharge_ctl u_discharge (
		.clk                (clk),
		.resetn             (resetn),
		.i_enable           (enable_bmp[`FSCPU_DBIT_DISCHARGE]),
		.i_req              (dis_req),
		.o_done             (done_bmp[`FSCPU_DBIT_DISCHARGE]),
		.o_discharge_resetn (o_discharge_resetn),
		.o_discharge_drive  (o_discharge_drive)
	);

endmodule

//--- verilog/req_decode.sv
`timescale 1ns/10ps
`include "fscpu_cfg.svh"

module req_decode (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             i_req_en,
	input  logic [31:0]                      i_req_cmd,
	input  logic [`FSCPU_PARAM_WORDS*32-1:0] i_req_param,
	output fscpu_pkg::req_s                  o_req
);
	import fscpu_pkg::*;

	logic                                valid_q;
	req_cmd_e                            cmd_q;
	logic [`FSCPU_PARAM_WORDS-1:0][31:0] par_q;

	// raw code to command, unknown codes fold into CMD_OTHER
	function automatic req_cmd_e classify(input logic [31:0] code);
		req_cmd_e cmd;
		case (code)
			CMD_MOTOR_LR:  cmd = CMD_MOTOR_LR;
			CMD_MOTOR_RR:  cmd = CMD_MOTOR_RR;
			CMD_DISCHARGE: cmd = CMD_DISCHARGE;
			CMD_CFG:       cmd = CMD_CFG;
			CMD_EXE:       cmd = CMD_EXE;
			CMD_STOP:      cmd = CMD_STOP;
			default:       cmd = CMD_OTHER;
		endcase
		return cmd;
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn)
			valid_q <= 1'b0;
		else
			valid_q <= i_req_en;	// single cycle strobe
	end

	always_ff @(posedge clk) begin
		if (i_req_en) begin
			cmd_q <= classify(i_req_cmd);
			for (int w = 0; w < `FSCPU_PARAM_WORDS; w++)
				par_q[w] <= i_req_param[w*32 +: 32];
		end
	end

	assign o_req = '{
		valid: valid_q,
		cmd:   cmd_q,
		par:   par_q
	};

endmodule
